// File: sdram_map_pkg.sv
// SDRAM memory map: word address width, region offsets, bank codes and slot address widths
package sdram_map_pkg;

    // SDRAM addresses count 16-bit words
    localparam int SDRAM_AW = 22;

    // Region offsets inside each bank
    localparam logic [SDRAM_AW-1:0] ROM_OFFSET   = 22'h00_0000;  // Main CPU code, bank 1
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET   = 22'h20_0000;  // Work RAM, bank 0
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET  = 22'h30_0000;  // Video RAM, bank 0
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET   = 22'h00_0000;  // Tiles and sprites, bank 2
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET = 22'h00_0000;  // Sound CPU code, bank 0

    // Bank codes
    localparam logic [1:0] BANK_ROM = 2'd1;
    localparam logic [1:0] BANK_GFX = 2'd2;
    localparam logic [1:0] BANK_SND = 2'd0;    // Main RAM lives here too

    // Client address widths, each in the client's own unit
    localparam int ROM_AW = 21;    // 16-bit words
    localparam int RAM_AW = 17;    // 16-bit words, RAM and VRAM share it
    localparam int GFX_AW = 20;    // 32-bit words
    localparam int SND_AW = 19;    // Bytes

endpackage

// File: sdram_slot_pkg.sv
// Slot format: slot count, slot identifiers and the 32-bit read word union
package sdram_slot_pkg;

    localparam int SLOT_N = 4;

    typedef logic [1:0] slot_id_t;

    // Slot numbers double as priority, lowest wins
    localparam slot_id_t SLOT_ROM = 2'd0;
    localparam slot_id_t SLOT_RAM = 2'd1;
    localparam slot_id_t SLOT_GFX = 2'd2;
    localparam slot_id_t SLOT_SND = 2'd3;

    // One SDRAM read seen as a word, two halves or four bytes
    // Half 0 and byte 0 sit at the low end
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } rd_word_u;

endpackage

// File: slot_arbiter.sv
`timescale 1ns/1ps
// Decode stage: fixed-priority slot arbiter with address scaling, bank, rnw and mask forming
module slot_arbiter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rom_cs,
    input  logic [sdram_map_pkg::ROM_AW-1:0]   rom_addr,
    input  logic                               ram_cs,
    input  logic [sdram_map_pkg::RAM_AW-1:0]   ram_addr,
    input  logic                               ram_wr,
    input  logic [15:0]                        ram_din,
    input  logic [1:0]                         ram_dsn,
    input  logic                               vram_sel,
    input  logic                               gfx_cs,
    input  logic [sdram_map_pkg::GFX_AW-1:0]   gfx_addr,
    input  logic                               snd_cs,
    input  logic [sdram_map_pkg::SND_AW-1:0]   snd_addr,
    input  logic                               busy,
    input  logic [sdram_slot_pkg::SLOT_N-1:0]  ok_vec,
    output logic                               grant_valid,
    output sdram_slot_pkg::slot_id_t           grant_slot,
    output logic [sdram_map_pkg::SDRAM_AW-1:0] grant_addr,
    output logic [1:0]                         grant_bank,
    output logic                               grant_rnw,
    output logic [1:0]                         grant_wrmask,
    output logic [15:0]                        grant_din,
    output logic                               grant_byte
);
    import sdram_map_pkg::*;
    import sdram_slot_pkg::*;

    logic [SLOT_N-1:0]   cs_vec;
    logic [SLOT_N-1:0]   pending;
    logic                any_pending;
    slot_id_t            sel;
    logic [SDRAM_AW-1:0] nxt_addr;
    logic [1:0]          nxt_bank;
    logic                nxt_rnw;
    logic [1:0]          nxt_mask;
    logic                nxt_byte;

    assign cs_vec = {snd_cs, gfx_cs, ram_cs, rom_cs};

    // A grant in flight to the sequencer counts as busy
    assign pending = cs_vec & ~ok_vec & {SLOT_N{~busy & ~grant_valid}};

    always_comb begin
        any_pending = 1'b0;
        sel         = SLOT_ROM;
        for (int i = SLOT_N - 1; i >= 0; i--) begin   // Scan down so the lowest wins
            if (pending[i]) begin
                any_pending = 1'b1;
                sel         = slot_id_t'(i);
            end
        end
    end

    // Request fields of the winner, ROM values by default
    always_comb begin
        nxt_addr = ROM_OFFSET + SDRAM_AW'(rom_addr);
        nxt_bank = BANK_ROM;
        nxt_rnw  = 1'b1;
        nxt_mask = 2'b11;
        nxt_byte = 1'b0;
        case (sel)
            SLOT_RAM: begin
                nxt_addr = (vram_sel ? VRAM_OFFSET : RAM_OFFSET) + SDRAM_AW'(ram_addr);
                nxt_bank = BANK_SND;
                nxt_rnw  = ~ram_wr;
                nxt_mask = ram_wr ? ram_dsn : 2'b11;   // dsn is active low like the mask
            end
            SLOT_GFX: begin
                nxt_addr = GFX_OFFSET + SDRAM_AW'({gfx_addr, 1'b0}); // Two words per access
                nxt_bank = BANK_GFX;
            end
            SLOT_SND: begin
                // Byte address, the low bit picks the byte on return
                nxt_addr = SOUND_OFFSET + SDRAM_AW'(snd_addr[SND_AW-1:1]);
                nxt_bank = BANK_SND;
                nxt_byte = snd_addr[0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= any_pending;   // One-cycle pulse, pending masks itself
        end
    end

    always_ff @(posedge clk) begin
        if (any_pending) begin
            grant_slot   <= sel;
            grant_addr   <= nxt_addr;
            grant_bank   <= nxt_bank;
            grant_rnw    <= nxt_rnw;
            grant_wrmask <= nxt_mask;
            grant_din    <= ram_din;
            grant_byte   <= nxt_byte;
        end
    end

    // The sequencer must be free by the time a grant reaches it
    a_grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
        grant_valid |-> !busy)
        else $error("Grant issued while the sequencer is busy");

endmodule

// File: sdram_sequencer.sv
`timescale 1ns/1ps
// Execute stage: FSM running the four-phase request and ack handshake with the SDRAM controller
module sdram_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               grant_valid,
    input  sdram_slot_pkg::slot_id_t           grant_slot,
    input  logic [sdram_map_pkg::SDRAM_AW-1:0] grant_addr,
    input  logic [1:0]                         grant_bank,
    input  logic                               grant_rnw,
    input  logic [1:0]                         grant_wrmask,
    input  logic [15:0]                        grant_din,
    input  logic                               grant_byte,
    input  logic                               sdram_ack,
    input  logic [31:0]                        data_read,
    output logic                               busy,
    output logic                               sdram_req,
    output logic [sdram_map_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [1:0]                         sdram_bank,
    output logic                               sdram_rnw,
    output logic [1:0]                         sdram_wrmask,
    output logic [15:0]                        data_write,
    output logic                               done,
    output sdram_slot_pkg::slot_id_t           done_slot,
    output logic                               done_byte,
    output sdram_slot_pkg::rd_word_u           rd_data
);
    import sdram_slot_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,    // req high, waiting for ack
        ST_REL     // req low, waiting for ack to drop
    } state_t;

    state_t state;

    // Covers the done cycle too so the slot is not granted again before its ok
    assign busy = (state != ST_IDLE) || done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (grant_valid) begin
                        state     <= ST_REQ;
                        sdram_req <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        state     <= ST_REL;
                        sdram_req <= 1'b0;
                    end
                end
                ST_REL: begin
                    if (!sdram_ack) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields stay put from grant until the next grant
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && grant_valid) begin
            sdram_addr   <= grant_addr;
            sdram_bank   <= grant_bank;
            sdram_rnw    <= grant_rnw;
            sdram_wrmask <= grant_wrmask;
            data_write   <= grant_din;
            done_slot    <= grant_slot;
            done_byte    <= grant_byte;
        end
        if (state == ST_REQ && sdram_ack) begin
            rd_data <= rd_word_u'(data_read);   // Valid only on the ack cycle
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before ack");

    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !sdram_ack)
        else $error("sdram_req raised while ack is still high");

endmodule

// File: slot_return.sv
`timescale 1ns/1ps
// Result stage: routes captured read data to the slot outputs and keeps the ok flags
module slot_return (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              done,
    input  sdram_slot_pkg::slot_id_t          done_slot,
    input  logic                              done_byte,
    input  sdram_slot_pkg::rd_word_u          rd_data,
    input  logic                              rom_cs,
    input  logic                              ram_cs,
    input  logic                              gfx_cs,
    input  logic                              snd_cs,
    output logic [sdram_slot_pkg::SLOT_N-1:0] ok_vec,
    output logic [15:0]                       rom_dout,
    output logic [15:0]                       ram_dout,
    output logic [31:0]                       gfx_dout,
    output logic [7:0]                        snd_dout,
    output logic                              rom_ok,
    output logic                              ram_ok,
    output logic                              gfx_ok,
    output logic                              snd_ok
);
    import sdram_slot_pkg::*;

    logic [SLOT_N-1:0] cs_vec;
    logic [SLOT_N-1:0] hit;

    assign cs_vec = {snd_cs, gfx_cs, ram_cs, rom_cs};
    assign hit    = done ? (SLOT_N'(1) << done_slot) : '0;   // One-hot finished slot

    assign {snd_ok, gfx_ok, ram_ok, rom_ok} = ok_vec;

    // Set on completion, held while cs stays high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ok_vec <= '0;
        end else begin
            ok_vec <= (ok_vec | hit) & cs_vec;
        end
    end

    // Each output only changes when its own slot completes
    always_ff @(posedge clk) begin
        if (done) begin
            case (done_slot)
                SLOT_ROM: rom_dout <= rd_data.halves[0];
                SLOT_RAM: ram_dout <= rd_data.halves[0];
                SLOT_GFX: gfx_dout <= rd_data.word;
                SLOT_SND: snd_dout <= done_byte ? rd_data.bytes[1] : rd_data.bytes[0];
            endcase
        end
    end

    // The client holds cs until ok, so a completion never finds it low
    for (genvar i = 0; i < SLOT_N; i++) begin : g_ok_chk
        a_done_cs: assert property (@(posedge clk) disable iff (!rst_n)
            hit[i] |-> cs_vec[i])
            else $error("Slot %0d completed while its cs is low", i);
    end

endmodule

// File: cps_sdram_mux.sv
`timescale 1ns/1ps
// Four-slot SDRAM access multiplexer top: arbiter, sequencer and return stages
module cps_sdram_mux (
    input  logic                               clk,
    input  logic                               rst_n,
    // Main CPU ROM
    input  logic                               rom_cs,
    input  logic [sdram_map_pkg::ROM_AW-1:0]   rom_addr,
    output logic                               rom_ok,
    output logic [15:0]                        rom_dout,
    // Main RAM and VRAM
    input  logic                               ram_cs,
    input  logic [sdram_map_pkg::RAM_AW-1:0]   ram_addr,
    input  logic                               ram_wr,
    input  logic [15:0]                        ram_din,
    input  logic [1:0]                         ram_dsn,
    input  logic                               vram_sel,
    output logic                               ram_ok,
    output logic [15:0]                        ram_dout,
    // Graphics ROM
    input  logic                               gfx_cs,
    input  logic [sdram_map_pkg::GFX_AW-1:0]   gfx_addr,
    output logic                               gfx_ok,
    output logic [31:0]                        gfx_dout,
    // Sound CPU ROM
    input  logic                               snd_cs,
    input  logic [sdram_map_pkg::SND_AW-1:0]   snd_addr,
    output logic                               snd_ok,
    output logic [7:0]                         snd_dout,
    // SDRAM controller
    output logic                               sdram_req,
    input  logic                               sdram_ack,
    output logic [sdram_map_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [1:0]                         sdram_bank,
    output logic                               sdram_rnw,
    output logic [1:0]                         sdram_wrmask,
    output logic [15:0]                        data_write,
    input  logic [31:0]                        data_read
);
    import sdram_map_pkg::*;
    import sdram_slot_pkg::*;

    // Arbiter to sequencer
    logic                grant_valid;
    slot_id_t            grant_slot;
    logic [SDRAM_AW-1:0] grant_addr;
    logic [1:0]          grant_bank;
    logic                grant_rnw;
    logic [1:0]          grant_wrmask;
    logic [15:0]         grant_din;
    logic                grant_byte;
    logic                busy;

    // Sequencer to return stage
    logic                done;
    slot_id_t            done_slot;
    logic                done_byte;
    rd_word_u            rd_data;

    logic [SLOT_N-1:0]   ok_vec;   // Fed back so finished slots are not granted again

    // Port names match the wires one to one
    slot_arbiter u_arbiter (.*);

    sdram_sequencer u_sequencer (.*);

    slot_return u_return (.*);

endmodule

// File: sdram_model.sv
`timescale 1ns/1ps
// SDRAM controller model with a four-phase ack of random delay over a sparse 16-bit word memory
module sdram_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    input  logic        sdram_rnw,
    input  logic [1:0]  sdram_wrmask,
    input  logic [15:0] data_write,
    output logic        sdram_ack,
    output logic [31:0] data_read
);
    logic [15:0] mem [int unsigned];   // Only written words live here
    logic        armed;
    int unsigned delay;

    // Unwritten words hold a pattern of their own address
    function automatic logic [15:0] peek(input logic [21:0] a);
        if (mem.exists(32'(a)))
            return mem[32'(a)];
        return a[15:0] ^ {10'h0, a[21:16]} ^ 16'h5a5a;
    endfunction

    // Low mask bit means the byte is written
    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input logic [1:0]  mask);
        return {mask[1] ? old[15:8] : data[15:8], mask[0] ? old[7:0] : data[7:0]};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_read <= '0;
            armed     <= 1'b0;
            delay     <= 0;
        end else if (sdram_ack) begin
            if (!sdram_req)
                sdram_ack <= 1'b0;   // Last phase
        end else if (sdram_req) begin
            if (!armed) begin
                armed <= 1'b1;
                delay <= $urandom % 6;   // Ack 1 to 6 cycles after req is seen
            end else if (delay != 0) begin
                delay <= delay - 1;
            end else begin
                armed     <= 1'b0;
                sdram_ack <= 1'b1;
                if (sdram_rnw) begin
                    data_read <= {peek(sdram_addr + 22'd1), peek(sdram_addr)};
                end else begin
                    mem[32'(sdram_addr)] = merge_bytes(peek(sdram_addr), data_write,
                                                       sdram_wrmask);
                end
            end
        end
    end

endmodule

// File: tb_cps_sdram_mux.sv
`timescale 1ns/1ps
// Testbench for the SDRAM mux with stimulus table, priority run, ok hold checks and timeouts
module tb_cps_sdram_mux;
    import sdram_map_pkg::*;
    import sdram_slot_pkg::*;

    localparam int WAIT_LIMIT = 100;   // Cycles

    logic                clk = 1'b0;
    logic                rst_n;
    logic                rom_cs;
    logic [ROM_AW-1:0]   rom_addr;
    logic                rom_ok;
    logic [15:0]         rom_dout;
    logic                ram_cs;
    logic [RAM_AW-1:0]   ram_addr;
    logic                ram_wr;
    logic [15:0]         ram_din;
    logic [1:0]          ram_dsn;
    logic                vram_sel;
    logic                ram_ok;
    logic [15:0]         ram_dout;
    logic                gfx_cs;
    logic [GFX_AW-1:0]   gfx_addr;
    logic                gfx_ok;
    logic [31:0]         gfx_dout;
    logic                snd_cs;
    logic [SND_AW-1:0]   snd_addr;
    logic                snd_ok;
    logic [7:0]          snd_dout;
    logic                sdram_req;
    logic                sdram_ack;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [1:0]          sdram_bank;
    logic                sdram_rnw;
    logic [1:0]          sdram_wrmask;
    logic [15:0]         data_write;
    logic [31:0]         data_read;
    logic                req_q = 1'b0;
    logic [21:0]         req_log[$];   // Address at each sdram_req rise

    // Stimulus table with one entry per index
    string               t_name[$];
    slot_id_t            t_slot[$];
    logic [21:0]         t_addr[$];
    logic                t_wr[$];
    logic [15:0]         t_data[$];
    logic [1:0]          t_mask[$];
    logic                t_vram[$];
    logic [31:0]         t_exp[$];
    logic [15:0]         shadow[int unsigned];   // Words written by the table

    always #4 clk = ~clk;

    cps_sdram_mux i_dut (.*);

    sdram_model u_sdram (.*);

    always @(posedge clk) begin
        req_q <= sdram_req;
        if (sdram_req && !req_q)
            req_log.push_back(sdram_addr);
    end

    function automatic logic [15:0] mem_word(input logic [21:0] a);
        if (shadow.exists(32'(a)))
            return shadow[32'(a)];
        return a[15:0] ^ {10'h0, a[21:16]} ^ 16'h5a5a;
    endfunction

    // SDRAM word address of a client access
    function automatic logic [21:0] word_addr(input slot_id_t slot, input logic [21:0] a,
                                              input logic vram);
        case (slot)
            SLOT_ROM: return ROM_OFFSET + a;
            SLOT_RAM: return (vram ? VRAM_OFFSET : RAM_OFFSET) + a;
            SLOT_GFX: return GFX_OFFSET + {a[20:0], 1'b0};   // 32-bit words
            default:  return SOUND_OFFSET + {1'b0, a[21:1]};
        endcase
    endfunction

    // Main RAM and sound share bank 0
    function automatic logic [1:0] slot_bank(input slot_id_t slot);
        case (slot)
            SLOT_ROM: return BANK_ROM;
            SLOT_GFX: return BANK_GFX;
            default:  return BANK_SND;
        endcase
    endfunction

    function automatic logic [31:0] expect_read(input slot_id_t slot, input logic [21:0] a,
                                                input logic vram);
        logic [21:0] w;
        logic [15:0] h;
        w = word_addr(slot, a, vram);
        h = mem_word(w);
        case (slot)
            SLOT_GFX: return {mem_word(w + 22'd1), h};
            SLOT_SND: return {24'h0, a[0] ? h[15:8] : h[7:0]};   // Odd byte is the high one
            default:  return {16'h0, h};
        endcase
    endfunction

    task automatic add_entry(input string name, input slot_id_t slot, input logic [21:0] a,
                             input logic wr, input logic [15:0] data, input logic [1:0] mask,
                             input logic vram);
        logic [21:0] w;
        logic [15:0] old;
        w   = word_addr(slot, a, vram);
        old = mem_word(w);
        t_name.push_back(name);
        t_slot.push_back(slot);
        t_addr.push_back(a);
        t_wr.push_back(wr);
        t_data.push_back(data);
        t_mask.push_back(mask);
        t_vram.push_back(vram);
        t_exp.push_back(wr ? 32'h0 : expect_read(slot, a, vram));
        if (wr)
            shadow[32'(w)] = {mask[1] ? old[15:8] : data[15:8], mask[0] ? old[7:0] : data[7:0]};
    endtask

    function automatic logic ok_of(input slot_id_t slot);
        case (slot)
            SLOT_ROM: return rom_ok;
            SLOT_RAM: return ram_ok;
            SLOT_GFX: return gfx_ok;
            default:  return snd_ok;
        endcase
    endfunction

    function automatic logic [31:0] dout_of(input slot_id_t slot);
        case (slot)
            SLOT_ROM: return {16'h0, rom_dout};
            SLOT_RAM: return {16'h0, ram_dout};
            SLOT_GFX: return gfx_dout;
            default:  return {24'h0, snd_dout};
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic wait_ok(input slot_id_t slot, input logic level, input string name);
        int cycles;
        cycles = 0;
        while (ok_of(slot) !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                fail_run($sformatf("Timeout in %s: ok of slot %0d never went to %0d",
                                   name, slot, level));
        end
    endtask

    task automatic drive_request(input int i);
        logic [21:0] a;
        a = t_addr[i];
        case (t_slot[i])
            SLOT_ROM: begin
                rom_addr <= a[ROM_AW-1:0];
                rom_cs   <= 1'b1;
            end
            SLOT_RAM: begin
                ram_addr <= a[RAM_AW-1:0];
                ram_wr   <= t_wr[i];
                ram_din  <= t_data[i];
                ram_dsn  <= t_mask[i];
                vram_sel <= t_vram[i];
                ram_cs   <= 1'b1;
            end
            SLOT_GFX: begin
                gfx_addr <= a[GFX_AW-1:0];
                gfx_cs   <= 1'b1;
            end
            default: begin
                snd_addr <= a[SND_AW-1:0];
                snd_cs   <= 1'b1;
            end
        endcase
    endtask

    task automatic release_slot(input slot_id_t slot);
        case (slot)
            SLOT_ROM: rom_cs <= 1'b0;
            SLOT_RAM: begin
                ram_cs <= 1'b0;
                ram_wr <= 1'b0;
            end
            SLOT_GFX: gfx_cs <= 1'b0;
            default:  snd_cs <= 1'b0;
        endcase
    endtask

    initial begin
        logic [31:0] held;
        void'($urandom(32'h288d_1814));
        rst_n    = 1'b0;
        rom_cs   = 1'b0;
        rom_addr = '0;
        ram_cs   = 1'b0;
        ram_addr = '0;
        ram_wr   = 1'b0;
        ram_din  = '0;
        ram_dsn  = 2'b11;
        vram_sel = 1'b0;
        gfx_cs   = 1'b0;
        gfx_addr = '0;
        snd_cs   = 1'b0;
        snd_addr = '0;

        add_entry("rom_read",      SLOT_ROM, 22'h00_1234, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("rom_read_top",  SLOT_ROM, 22'h1f_fffe, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("ram_read",      SLOT_RAM, 22'h00_0345, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("vram_read",     SLOT_RAM, 22'h00_0345, 1'b0, 16'h0000, 2'b11, 1'b1);
        add_entry("gfx_read",      SLOT_GFX, 22'h00_1001, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("snd_even",      SLOT_SND, 22'h00_4566, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("snd_odd",       SLOT_SND, 22'h00_4567, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("ram_write_lo",  SLOT_RAM, 22'h00_0345, 1'b1, 16'hbeef, 2'b10, 1'b0);
        add_entry("ram_readback",  SLOT_RAM, 22'h00_0345, 1'b0, 16'h0000, 2'b11, 1'b0);
        add_entry("vram_write_hi", SLOT_RAM, 22'h01_0010, 1'b1, 16'hc3a5, 2'b01, 1'b1);
        add_entry("vram_readback", SLOT_RAM, 22'h01_0010, 1'b0, 16'h0000, 2'b11, 1'b1);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check_value("reset_req", 32'h0, 32'(sdram_req));
        check_value("reset_ok", 32'h0, {28'h0, snd_ok, gfx_ok, ram_ok, rom_ok});

        foreach (t_name[i]) begin
            @(posedge clk);
            drive_request(i);
            wait_ok(t_slot[i], 1'b1, t_name[i]);
            held = dout_of(t_slot[i]);
            if (!t_wr[i])
                check_value(t_name[i], t_exp[i], held);
            // Bank of the finished access is still on the bus
            check_value({t_name[i], "_bank"}, 32'(slot_bank(t_slot[i])), 32'(sdram_bank));
            repeat (3) begin   // Ok and dout must not move while cs stays high
                @(posedge clk);
                check_value({t_name[i], "_ok_hold"}, 32'h1, 32'(ok_of(t_slot[i])));
                check_value({t_name[i], "_dout_hold"}, held, dout_of(t_slot[i]));
            end
            release_slot(t_slot[i]);
            wait_ok(t_slot[i], 1'b0, t_name[i]);
        end

        // Three slots on the same edge
        req_log.delete();
        @(posedge clk);
        rom_addr <= 21'h0_0abc;
        ram_addr <= 17'h0_0abc;
        ram_wr   <= 1'b0;
        vram_sel <= 1'b0;
        gfx_addr <= 20'h0_0abc;
        rom_cs   <= 1'b1;
        ram_cs   <= 1'b1;
        gfx_cs   <= 1'b1;
        wait_ok(SLOT_ROM, 1'b1, "prio_rom");
        wait_ok(SLOT_RAM, 1'b1, "prio_ram");
        wait_ok(SLOT_GFX, 1'b1, "prio_gfx");
        check_value("prio_count", 32'd3, 32'(req_log.size()));
        check_value("prio_first", {10'h0, word_addr(SLOT_ROM, 22'h000abc, 1'b0)},
                    {10'h0, req_log[0]});
        check_value("prio_second", {10'h0, word_addr(SLOT_RAM, 22'h000abc, 1'b0)},
                    {10'h0, req_log[1]});
        check_value("prio_third", {10'h0, word_addr(SLOT_GFX, 22'h000abc, 1'b0)},
                    {10'h0, req_log[2]});
        check_value("prio_gfx_data", expect_read(SLOT_GFX, 22'h000abc, 1'b0), gfx_dout);
        rom_cs <= 1'b0;
        ram_cs <= 1'b0;
        gfx_cs <= 1'b0;
        wait_ok(SLOT_ROM, 1'b0, "prio_rom_release");
        wait_ok(SLOT_RAM, 1'b0, "prio_ram_release");
        wait_ok(SLOT_GFX, 1'b0, "prio_gfx_release");

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: cps_sdram_mux.f
sdram_map_pkg.sv
sdram_slot_pkg.sv
slot_arbiter.sv
sdram_sequencer.sv
slot_return.sv
cps_sdram_mux.sv
sdram_model.sv
tb_cps_sdram_mux.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_cps_sdram_mux
FILELIST  := cps_sdram_mux.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
